/* Makefile */
VERILATOR ?= verilator
TOP       ?= exe_stage_tb
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Test completed successfully
VFLAGS    ?= --binary --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: build
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* build.f */
hw/exe_pkg.sv
hw/alu.sv
hw/branch_unit.sv
hw/mul_unit.sv
hw/operand_forward.sv
hw/mem_access.sv
hw/exe_stage.sv
tests/exe_stage_tb.sv

/* hw/alu.sv */
`timescale 1ns/1ns

module alu (
    input  exe_pkg::func_t op,
    input  exe_pkg::word_t a,
    input  exe_pkg::word_t b,
    output exe_pkg::word_t result
);
    import exe_pkg::*;

    logic [4:0] shamt;

    assign shamt = b[4:0];

    always_comb begin
        case (op)
            ALU_ADD:  result = a + b;
            ALU_SUB:  result = a - b;
            ALU_AND:  result = a & b;
            ALU_OR:   result = a | b;
            ALU_XOR:  result = a ^ b;
            ALU_SLL:  result = a << shamt;
            ALU_SRL:  result = a >> shamt;
            ALU_SRA:  result = word_t'($signed(a) >>> shamt);
            ALU_SLT:  result = {31'd0, $signed(a) < $signed(b)};
            ALU_SLTU: result = {31'd0, a < b};
            default:  result = '0;
        endcase
    end

endmodule

/* hw/branch_unit.sv */
`timescale 1ns/1ns

module branch_unit (
    input  exe_pkg::func_t func,
    input  exe_pkg::word_t pc,
    input  exe_pkg::word_t imm,
    input  exe_pkg::word_t src0,
    input  exe_pkg::word_t src1,
    output logic           taken,
    output exe_pkg::word_t target,
    output exe_pkg::word_t link
);
    import exe_pkg::*;

    logic eq;
    logic lt_s;
    logic lt_u;

    assign eq   = src0 == src1;
    assign lt_s = $signed(src0) < $signed(src1);
    assign lt_u = src0 < src1;

    always_comb begin
        case (func)
            BR_JIRL, BR_B, BR_BL: taken = 1'b1;  // unconditional
            BR_BEQ:  taken = eq;
            BR_BNE:  taken = !eq;
            BR_BLT:  taken = lt_s;
            BR_BGE:  taken = !lt_s;
            BR_BLTU: taken = lt_u;
            BR_BGEU: taken = !lt_u;
            default: taken = 1'b0;
        endcase
    end

    // jirl is register relative, the rest pc relative
    assign target = (func == BR_JIRL ? src0 : pc) + imm;
    assign link   = pc + 32'd4;

endmodule

/* hw/exe_pkg.sv */
package exe_pkg;

    typedef logic [31:0] word_t;      // data word or word address
    typedef logic [4:0]  reg_addr_t;
    typedef logic [2:0]  kind_t;
    typedef logic [3:0]  func_t;
    typedef logic [33:0] pp_t;        // 17x17 signed product

    localparam kind_t KIND_NONE  = 3'd0;
    localparam kind_t KIND_ALU   = 3'd1;
    localparam kind_t KIND_BR    = 3'd2;
    localparam kind_t KIND_MUL   = 3'd3;
    localparam kind_t KIND_LOAD  = 3'd4;
    localparam kind_t KIND_STORE = 3'd5;

    localparam func_t ALU_ADD  = 4'd0;
    localparam func_t ALU_SUB  = 4'd1;
    localparam func_t ALU_AND  = 4'd2;
    localparam func_t ALU_OR   = 4'd3;
    localparam func_t ALU_XOR  = 4'd4;
    localparam func_t ALU_SLL  = 4'd5;
    localparam func_t ALU_SRL  = 4'd6;
    localparam func_t ALU_SRA  = 4'd7;
    localparam func_t ALU_SLT  = 4'd8;
    localparam func_t ALU_SLTU = 4'd9;

    // branch conditions
    localparam func_t BR_JIRL = 4'd3;
    localparam func_t BR_B    = 4'd4;
    localparam func_t BR_BL   = 4'd5;
    localparam func_t BR_BEQ  = 4'd6;
    localparam func_t BR_BNE  = 4'd7;
    localparam func_t BR_BLT  = 4'd8;
    localparam func_t BR_BGE  = 4'd9;
    localparam func_t BR_BLTU = 4'd10;
    localparam func_t BR_BGEU = 4'd11;

    localparam func_t MUL_LO  = 4'd0;
    localparam func_t MUL_HI  = 4'd1;
    localparam func_t MUL_HIU = 4'd2;  // unsigned high word

endpackage

/* hw/exe_stage.sv */
`timescale 1ns/1ns

module exe_stage (
    input  logic                clk,
    input  logic                rst,
    input  logic                eu0_valid,
    input  exe_pkg::kind_t      eu0_kind,
    input  exe_pkg::func_t      eu0_func,
    input  exe_pkg::reg_addr_t  eu0_rd, eu0_rj, eu0_rk,
    input  exe_pkg::word_t      eu0_rj_data, eu0_rk_data, eu0_imm, eu0_pc,
    input  logic                eu1_valid,
    input  exe_pkg::kind_t      eu1_kind,
    input  exe_pkg::func_t      eu1_func,
    input  exe_pkg::reg_addr_t  eu1_rd, eu1_rj, eu1_rk,
    input  exe_pkg::word_t      eu1_rj_data, eu1_rk_data,
    output logic                stall,
    output logic                flush,
    output exe_pkg::word_t      br_target,
    output logic                en_out0, en_out1,
    output exe_pkg::reg_addr_t  rd_out0, rd_out1,
    output exe_pkg::word_t      data_out0, data_out1,
    output logic                mem_req, mem_we,
    output exe_pkg::word_t      mem_addr, mem_wdata,
    input  exe_pkg::word_t      mem_rdata,
    input  logic                mem_ack
);
    import exe_pkg::*;

    logic      alu0_en, br_en, mul_en, mem_en, alu1_en, link_en;
    logic      taken, use_stall, wait_cache, done_en;
    word_t     alu0_res, alu1_res, link, mul_product, done_data;
    reg_addr_t done_rd;
    reg_addr_t src [4];
    word_t     rf_data [4];
    word_t     opnd [4];  // eu0 rj, eu0 rk, eu1 rj, eu1 rk
    logic      mid0_en, mid0_mul, mid1_en;
    reg_addr_t mid0_rd, mid1_rd;
    word_t     mid0_data, mid1_data;
    logic      out0_en, out1_en, out_hold;

    assign alu0_en = eu0_valid && eu0_kind == KIND_ALU;
    assign br_en   = eu0_valid && eu0_kind == KIND_BR;
    assign mul_en  = eu0_valid && eu0_kind == KIND_MUL;
    assign mem_en  = eu0_valid && (eu0_kind == KIND_LOAD || eu0_kind == KIND_STORE);
    assign alu1_en = eu1_valid && eu1_kind == KIND_ALU;
    assign link_en = br_en && (eu0_func == BR_BL || eu0_func == BR_JIRL);

    assign src     = '{eu0_rj, eu0_rk, eu1_rj, eu1_rk};
    assign rf_data = '{eu0_rj_data, eu0_rk_data, eu1_rj_data, eu1_rk_data};

    for (genvar i = 0; i < 4; i++) begin : g_fwd
        operand_forward i_fwd (
            .src(src[i]), .rf_data(rf_data[i]),
            .mid0_en(mid0_en), .mid0_rd(mid0_rd), .mid0_data(mid0_data),
            .mid1_en(mid1_en), .mid1_rd(mid1_rd), .mid1_data(mid1_data),
            .out0_en(out0_en), .out0_rd(rd_out0), .out0_data(data_out0),
            .out1_en(out1_en), .out1_rd(rd_out1), .out1_data(data_out1),
            .value(opnd[i])
        );
    end

    alu i_alu0 (.op(eu0_func), .a(opnd[0]), .b(opnd[1]), .result(alu0_res));
    alu i_alu1 (.op(eu1_func), .a(opnd[2]), .b(opnd[3]), .result(alu1_res));

    branch_unit i_branch (
        .func(eu0_func), .pc(eu0_pc), .imm(eu0_imm), .src0(opnd[0]), .src1(opnd[1]),
        .taken(taken), .target(br_target), .link(link)
    );

    mul_unit i_mul (
        .clk(clk), .rst(rst), .advance(!wait_cache), .func(eu0_func),
        .a(opnd[0]), .b(opnd[1]), .product(mul_product)
    );

    mem_access i_mem (
        .clk(clk), .rst(rst), .start(mem_en && !stall), .we(eu0_kind == KIND_STORE),
        .base(opnd[0]), .imm(eu0_imm), .wdata(opnd[1]), .rd(eu0_rd),
        .mem_ack(mem_ack), .mem_rdata(mem_rdata), .mem_req(mem_req), .mem_we(mem_we),
        .wait_cache(wait_cache), .done_en(done_en), .done_rd(done_rd),
        .done_data(done_data), .mem_addr(mem_addr), .mem_wdata(mem_wdata)
    );

    // load or multiply in mid has no data for forwarding yet
    always_comb begin
        use_stall = 1'b0;
        for (int i = 0; i < 4; i++) begin
            if ((i < 2 ? eu0_valid : eu1_valid) && src[i] != '0 &&
                ((mem_req && !mem_we && src[i] == done_rd) ||
                 (mid0_mul && src[i] == mid0_rd)))
                use_stall = 1'b1;
        end
    end

    assign stall = use_stall || wait_cache;
    assign flush = br_en && taken && !stall;

    always_ff @(posedge clk) begin
        if (rst) begin
            mid0_en  <= 1'b0;
            mid0_mul <= 1'b0;
            mid1_en  <= 1'b0;
        end else if (!wait_cache) begin
            mid0_en  <= (alu0_en || link_en) && !use_stall;  // bubble on use stall
            mid0_mul <= mul_en && !use_stall;
            mid1_en  <= alu1_en && !use_stall;
        end
    end

    always_ff @(posedge clk) begin
        if (!wait_cache) begin
            mid0_rd   <= eu0_rd;
            mid0_data <= br_en ? link : alu0_res;
            mid1_rd   <= eu1_rd;
            mid1_data <= alu1_res;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out0_en  <= 1'b0;
            out1_en  <= 1'b0;
            out_hold <= 1'b0;
        end else if (!wait_cache) begin
            out0_en  <= mid0_en || mid0_mul || done_en;
            out1_en  <= mid1_en;
            out_hold <= 1'b0;
        end else begin
            out_hold <= 1'b1;  // frozen entry already presented once
        end
    end

    // lane 0 sources are one-hot by kind
    always_ff @(posedge clk) begin
        if (!wait_cache) begin
            rd_out0   <= (mid0_en || mid0_mul) ? mid0_rd : done_rd;
            data_out0 <= (mid0_en ? mid0_data : '0) | (mid0_mul ? mul_product : '0) | done_data;
            rd_out1   <= mid1_rd;
            data_out1 <= mid1_data;
        end
    end

    assign en_out0 = out0_en && !out_hold;
    assign en_out1 = out1_en && !out_hold;

endmodule

/* hw/mem_access.sv */
`timescale 1ns/1ns

module mem_access (
    input  logic               clk,
    input  logic               rst,
    input  logic               start,
    input  logic               we,
    input  exe_pkg::word_t     base,
    input  exe_pkg::word_t     imm,
    input  exe_pkg::word_t     wdata,
    input  exe_pkg::reg_addr_t rd,
    input  logic               mem_ack,
    input  exe_pkg::word_t     mem_rdata,
    output logic               mem_req,
    output logic               mem_we,
    output logic               wait_cache,
    output logic               done_en,
    output exe_pkg::reg_addr_t done_rd,
    output exe_pkg::word_t     done_data,
    output exe_pkg::word_t     mem_addr,
    output exe_pkg::word_t     mem_wdata
);

    // a new request may follow straight after the ack
    always_ff @(posedge clk) begin
        if (rst) begin
            mem_req <= 1'b0;
            mem_we  <= 1'b0;
        end else if (start) begin
            mem_req <= 1'b1;
            mem_we  <= we;
        end else if (mem_ack) begin
            mem_req <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            mem_addr  <= base + imm;
            mem_wdata <= wdata;
            done_rd   <= rd;
        end
    end

    assign wait_cache = mem_req && !mem_ack;
    assign done_en    = mem_req && mem_ack && !mem_we;  // stores write nothing back
    assign done_data  = done_en ? mem_rdata : '0;       // zero so it can be or-merged

endmodule

/* hw/mul_unit.sv */
`timescale 1ns/1ns

module mul_unit (
    input  logic           clk,
    input  logic           rst,
    input  logic           advance,
    input  exe_pkg::func_t func,
    input  exe_pkg::word_t a,
    input  exe_pkg::word_t b,
    output exe_pkg::word_t product
);
    import exe_pkg::*;

    logic               sgn;
    logic [16:0]        a_hi, a_lo;
    logic [16:0]        b_hi, b_lo;
    pp_t                pp_d [4];
    pp_t                pp_q [4];
    func_t              func_q;
    logic signed [63:0] sum;

    // upper halves carry the sign, lower halves are always positive
    assign sgn  = func != MUL_HIU;
    assign a_hi = {sgn & a[31], a[31:16]};
    assign a_lo = {1'b0, a[15:0]};
    assign b_hi = {sgn & b[31], b[31:16]};
    assign b_lo = {1'b0, b[15:0]};

    assign pp_d[0] = 34'($signed(a_lo)) * 34'($signed(b_lo));
    assign pp_d[1] = 34'($signed(a_hi)) * 34'($signed(b_lo));
    assign pp_d[2] = 34'($signed(a_lo)) * 34'($signed(b_hi));
    assign pp_d[3] = 34'($signed(a_hi)) * 34'($signed(b_hi));

    always_ff @(posedge clk) begin
        if (rst)
            func_q <= MUL_LO;
        else if (advance)
            func_q <= func;
    end

    always_ff @(posedge clk) begin
        if (advance)
            pp_q <= pp_d;
    end

    assign sum = 64'($signed(pp_q[0]))
               + (64'($signed(pp_q[1])) << 16)
               + (64'($signed(pp_q[2])) << 16)
               + (64'($signed(pp_q[3])) << 32);

    assign product = (func_q == MUL_HI || func_q == MUL_HIU) ? sum[63:32] : sum[31:0];

endmodule

/* hw/operand_forward.sv */
`timescale 1ns/1ns

module operand_forward (
    input  exe_pkg::reg_addr_t src,
    input  exe_pkg::word_t     rf_data,
    input  logic               mid0_en,
    input  logic               mid1_en,
    input  exe_pkg::reg_addr_t mid0_rd,
    input  exe_pkg::reg_addr_t mid1_rd,
    input  exe_pkg::word_t     mid0_data,
    input  exe_pkg::word_t     mid1_data,
    input  logic               out0_en,
    input  logic               out1_en,
    input  exe_pkg::reg_addr_t out0_rd,
    input  exe_pkg::reg_addr_t out1_rd,
    input  exe_pkg::word_t     out0_data,
    input  exe_pkg::word_t     out1_data,
    output exe_pkg::word_t     value
);

    // youngest producer first, lane 1 is younger within a pair
    always_comb begin
        if (src == '0)
            value = '0;
        else if (mid1_en && mid1_rd == src)
            value = mid1_data;
        else if (mid0_en && mid0_rd == src)
            value = mid0_data;
        else if (out1_en && out1_rd == src)
            value = out1_data;
        else if (out0_en && out0_rd == src)
            value = out0_data;
        else
            value = rf_data;
    end

endmodule

/* tests/exe_stage_tb.sv */
`timescale 1ns/1ns

module exe_stage_tb;
    import exe_pkg::*;

    localparam int NUM_REC = 34;
    localparam int FIELDS  = 12;  // c0 rj0 rk0 imm pc c1 rj1 rk1 exp0 exp1 flags target

    logic [31:0] testdata [NUM_REC*FIELDS];
    word_t       cache_mem [64];
    logic [36:0] exp_q0 [$];      // {rd, data}
    logic [36:0] exp_q1 [$];
    integer      seed = 40926;
    int          wait_cnt;
    int          rec;
    logic        accepted;
    logic [31:0] flags;

    logic      clk, rst;
    logic      eu0_valid, eu1_valid;
    kind_t     eu0_kind, eu1_kind;
    func_t     eu0_func, eu1_func;
    reg_addr_t eu0_rd, eu0_rj, eu0_rk, eu1_rd, eu1_rj, eu1_rk;
    word_t     eu0_rj_data, eu0_rk_data, eu0_imm, eu0_pc, eu1_rj_data, eu1_rk_data;
    logic      stall, flush, en_out0, en_out1, mem_req, mem_we;
    logic      mem_ack = 1'b0;
    word_t     br_target, data_out0, data_out1, mem_addr, mem_wdata;
    word_t     mem_rdata = '0;
    reg_addr_t rd_out0, rd_out1;

    exe_stage i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("Error at %0t ns: %s = %h, expected %h", $time, name, got, exp);
            $display("Test failed");
            $fatal(1);
        end
    endtask

    task automatic drive_idle();
        eu0_valid <= 1'b0;
        eu0_kind  <= KIND_NONE;
        {eu0_func, eu0_rd, eu0_rj, eu0_rk} <= '0;
        {eu0_rj_data, eu0_rk_data, eu0_imm, eu0_pc} <= '0;
        eu1_valid <= 1'b0;
        eu1_kind  <= KIND_NONE;
        {eu1_func, eu1_rd, eu1_rj, eu1_rk, eu1_rj_data, eu1_rk_data} <= '0;
    endtask

    // ctrl word holds kind, func, rd, rj, rk as hex digit fields
    task automatic drive_record(input int r);
        logic [31:0] c0;
        logic [31:0] c1;
        int          b;
        b  = r * FIELDS;
        c0 = testdata[b];
        c1 = testdata[b+5];
        eu0_valid   <= c0[30:28] != KIND_NONE;
        eu0_kind    <= c0[30:28];
        eu0_func    <= c0[27:24];
        eu0_rd      <= c0[20:16];
        eu0_rj      <= c0[12:8];
        eu0_rk      <= c0[4:0];
        eu0_rj_data <= testdata[b+1];
        eu0_rk_data <= testdata[b+2];
        eu0_imm     <= testdata[b+3];
        eu0_pc      <= testdata[b+4];
        eu1_valid   <= c1[30:28] != KIND_NONE;
        eu1_kind    <= c1[30:28];
        eu1_func    <= c1[27:24];
        eu1_rd      <= c1[20:16];
        eu1_rj      <= c1[12:8];
        eu1_rk      <= c1[4:0];
        eu1_rj_data <= testdata[b+6];
        eu1_rk_data <= testdata[b+7];
    endtask

    task automatic check_writeback(input int lane, input reg_addr_t rd, input word_t data);
        logic [36:0] exp;
        if ((lane == 0 ? exp_q0.size() : exp_q1.size()) == 0) begin
            $display("Error at %0t ns: lane %0d wrote back r%0d with nothing expected",
                     $time, lane, rd);
            $display("Test failed");
            $fatal(1);
        end
        exp = (lane == 0) ? exp_q0.pop_front() : exp_q1.pop_front();
        check_value(lane == 0 ? "rd_out0" : "rd_out1", 32'(rd), 32'(exp[36:32]));
        check_value(lane == 0 ? "data_out0" : "data_out1", data, exp[31:0]);
    endtask

    always @(negedge clk) begin
        if (!rst && en_out0)
            check_writeback(0, rd_out0, data_out0);
        if (!rst && en_out1)
            check_writeback(1, rd_out1, data_out1);
    end

    // cache model acks after 0 to 3 extra cycles
    initial begin
        for (int i = 0; i < 64; i++)
            cache_mem[i] = 32'h5a5a0000 ^ (i * 32'h00010003);
    end

    always @(posedge clk) begin
        if (rst) begin
            mem_ack   <= 1'b0;
            mem_rdata <= '0;
            wait_cnt = -1;
        end else begin
            mem_ack <= 1'b0;
            if (mem_req && !mem_ack) begin
                if (wait_cnt < 0)
                    wait_cnt = {$random(seed)} % 4;
                if (wait_cnt == 0) begin
                    mem_ack   <= 1'b1;
                    mem_rdata <= cache_mem[mem_addr[5:0]];
                    if (mem_we)
                        cache_mem[mem_addr[5:0]] = mem_wdata;
                    wait_cnt = -1;
                end else begin
                    wait_cnt--;
                end
            end
        end
    end

    initial begin
        #(NUM_REC * 10 * 20 + 4 * 20);
        $display("Error: watchdog expired before all results were seen");
        $display("Test failed");
        $fatal(1);
    end

    initial begin
        $readmemh("tests/exe_testdata.txt", testdata);
        rst = 1'b1;
        drive_idle();
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        drive_record(0);
        rec = 0;
        while (rec < NUM_REC) begin
            @(negedge clk);
            accepted = !stall;  // stable until the next rising edge
            if (accepted) begin
                flags = testdata[rec*FIELDS+10];
                check_value("flush", 32'(flush), 32'(flags[0]));
                if (flags[0])
                    check_value("br_target", br_target, testdata[rec*FIELDS+11]);
                if (flags[1])
                    exp_q0.push_back({testdata[rec*FIELDS][20:16], testdata[rec*FIELDS+8]});
                if (flags[2])
                    exp_q1.push_back({testdata[rec*FIELDS+5][20:16], testdata[rec*FIELDS+9]});
            end
            @(posedge clk);
            if (accepted) begin
                rec++;
                if (rec < NUM_REC)
                    drive_record(rec);
                else
                    drive_idle();
            end
        end
        while (exp_q0.size() > 0 || exp_q1.size() > 0)
            @(negedge clk);
        repeat (4) @(negedge clk);  // catch stray writebacks
        $display("Test completed successfully");
        $finish;
    end

endmodule

/* tests/exe_testdata.txt */
// c0 rj0 rk0 imm pc c1 rj1 rk1 exp0 exp1 flags target
// ctrl = kind func rd rj rk, flags bit0 flush bit1 lane0 writes bit2 lane1 writes
10070102 5 fffffff3 0 0 11080304 12345678 c fffffff8 1234566c 6 0
12090302 12345678 fffffff3 0 0 130a0104 5 c 12345670 d 6 0
140b0301 12345678 5 0 0 150c0306 12345678 4 1234567d 23456780 6 0
160d0506 80000000 4 0 0 170e0506 80000000 4 08000000 f8000000 6 0
180f0201 fffffff3 5 0 0 19100201 fffffff3 5 1 0 6 0
10110708 fffffff8 1234566c 0 0 11120100 5 deadbeef 12345664 5 6 0
10131101 deadbeef 5 0 0 14141211 deadbeef deadbeef 12345669 12345661 6 0
11151214 deadbeef deadbeef 0 0 10161311 deadbeef deadbeef edcba9a4 2468accd 6 0
10000303 12345678 12345678 0 0 13170000 deadbeef deadbeef 2468acf0 0 6 0
30180203 fffffff3 12345678 0 0 0 0 0 13579be8 0 2 0
10191801 deadbeef 5 0 0 101a1818 deadbeef deadbeef 13579bed 26af37d0 6 0
311b0203 fffffff3 12345678 0 0 0 0 0 ffffffff 0 2 0
321c0504 80000000 c 0 0 0 0 0 6 0 2 0
301d0202 fffffff3 fffffff3 0 0 191f011c 5 deadbeef a9 1 6 0
321e0202 fffffff3 fffffff3 0 0 0 0 0 ffffffe6 0 2 0
10011d1e a9 deadbeef 0 0 0 0 0 8f 0 2 0
50000403 c 12345678 10 0 10020606 4 4 0 8 4 0
40050400 c 0 10 0 0 0 0 12345678 0 2 0
10060502 deadbeef 8 0 0 11070501 deadbeef 8f 12345680 123455e9 6 0
50000006 0 deadbeef 20 0 0 0 0 0 0 0 0
50000007 0 123455e9 21 0 0 0 0 0 0 0 0
40080000 0 0 20 0 14090607 12345680 123455e9 12345680 369 6 0
400a0000 0 0 21 0 0 0 0 123455e9 0 2 0
100b080a 12345680 deadbeef 0 0 0 0 0 2468ac69 0 2 0
26000303 12345678 12345678 40 1000 100c0101 8f 8f 0 11e 5 1040
27000303 12345678 12345678 40 1004 0 0 0 0 0 0 0
28000201 8 8f fffffff0 1008 0 0 0 0 0 1 ff8
29000d0e 08000000 f8000000 8 100c 0 0 0 0 0 1 1014
2a000d0e 08000000 f8000000 100 1010 0 0 0 0 0 1 1110
2b000d0e 08000000 f8000000 100 1014 0 0 0 0 0 0 0
25010000 0 0 400 2000 0 0 0 2004 0 3 2400
23020100 deadbeef 0 8 2400 0 0 0 2404 0 3 200c
24000000 0 0 10 3000 10030200 deadbeef 0 0 2404 5 3010
26000102 2004 2404 10 3004 0 0 0 0 0 0 0
